// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

	localparam int OVERSAMPLE = 16;	// baud_tick cycles per serial bit
	localparam int MID_SAMPLE = 7;	// start bit is checked this many cycles after the edge
	localparam int FIFO_DEPTH = 8;	// entries per fifo

	localparam int ADDR_W = 2;
	localparam int DATA_W = 8;	// host data and widest character

	// register map
	localparam logic [ADDR_W-1:0] ADDR_DATA   = 2'd0;	// tx push on write, rx pop on read
	localparam logic [ADDR_W-1:0] ADDR_CTRL   = 2'd1;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd2;	// write ones to clear sticky errors

	// character length, code n means n+5 data bits
	typedef enum logic [1:0] {
		LEN_5 = 2'd0,
		LEN_6 = 2'd1,
		LEN_7 = 2'd2,
		LEN_8 = 2'd3
	} data_len_t;

	// line format, low 5 bits of CTRL
	typedef struct packed {
		data_len_t data_len;	// bits 4:3
		logic      parity_en;	// bit 2
		logic      parity_odd;	// bit 1, else even
		logic      stop_two;	// bit 0, else one stop bit
	} uart_cfg_t;

	// 8N1 out of reset
	localparam uart_cfg_t CTRL_RESET = '{
		data_len:   LEN_8,
		parity_en:  1'b0,
		parity_odd: 1'b0,
		stop_two:   1'b0
	};

	// one received character with its line errors
	typedef struct packed {
		logic [DATA_W-1:0] data;	// zero above the configured length
		logic              parity_err;
		logic              frame_err;	// a stop sample was low
	} rx_word_t;

	// STATUS read value, msb first
	typedef struct packed {
		logic rx_overrun;	// sticky
		logic frame_err;	// sticky
		logic parity_err;	// sticky
		logic tx_full;
		logic tx_empty;
		logic rx_full;
		logic rx_avail;
		logic tx_busy;
	} uart_status_t;

endpackage

`default_nettype wire

// File: source/uart_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sync_fifo #(
	parameter type payload_t = logic [uart_pkg::DATA_W-1:0],
	parameter int  DEPTH     = uart_pkg::FIFO_DEPTH
) (
	input  logic     baud_tick,
	input  logic     PRESETn,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t head_o,	// fall-through, valid while not empty
	output logic     full_o,
	output logic     empty_o,
	output logic     overrun_o	// one cycle after a dropped push
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// occupancy
	logic             do_push;
	logic             do_pop;

	// wraps at DEPTH, so any depth works
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full_o  = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full_o;	// full drops the word, stored ones stay
	assign do_pop  = pop_i && !empty_o;
	assign head_o  = mem[rd_ptr];

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			overrun_o <= 1'b0;
		end else begin
			overrun_o <= push_i && full_o;
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge baud_tick) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

`default_nettype wire

// File: source/uart_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cfg_regs (
	input  logic                        baud_tick,
	input  logic                        PRESETn,
	input  logic                        reg_wr_i,
	input  logic                        reg_rd_i,
	input  logic [uart_pkg::ADDR_W-1:0] reg_addr_i,
	input  logic [uart_pkg::DATA_W-1:0] reg_wdata_i,
	output logic [uart_pkg::DATA_W-1:0] reg_rdata_o,
	output logic                        irq_o,
	output uart_pkg::uart_cfg_t         cfg_o,
	output logic                        tx_push_o,
	input  logic                        tx_full_i,
	input  logic                        tx_empty_i,
	input  logic                        tx_busy_i,
	output logic                        rx_pop_o,
	input  uart_pkg::rx_word_t          rx_head_i,
	input  logic                        rx_avail_i,
	input  logic                        rx_full_i,
	input  logic                        rx_overrun_i
);
	import uart_pkg::*;

	uart_cfg_t         cfg_q;	// line format register
	uart_status_t      status;
	logic              sticky_ovr;
	logic              sticky_frm;
	logic              sticky_par;
	logic              wr_data, wr_ctrl, wr_status;
	logic              rd_data;
	logic [DATA_W-1:0] len_mask;	// ones for the configured data bits
	logic [DATA_W-1:0] rd_mux;

	// host strobe decode
	assign wr_data   = reg_wr_i && (reg_addr_i == ADDR_DATA);
	assign wr_ctrl   = reg_wr_i && (reg_addr_i == ADDR_CTRL);
	assign wr_status = reg_wr_i && (reg_addr_i == ADDR_STATUS);
	assign rd_data   = reg_rd_i && (reg_addr_i == ADDR_DATA);

	assign tx_push_o = wr_data;	// fifo drops it when full
	assign rx_pop_o  = rd_data && rx_avail_i;	// no pop on an empty fifo
	assign cfg_o     = cfg_q;

	assign len_mask = {DATA_W{1'b1}} >> (2'd3 - 2'(cfg_q.data_len));

	assign status = '{
		rx_overrun: sticky_ovr,
		frame_err:  sticky_frm,
		parity_err: sticky_par,
		tx_full:    tx_full_i,
		tx_empty:   tx_empty_i,
		rx_full:    rx_full_i,
		rx_avail:   rx_avail_i,
		tx_busy:    tx_busy_i
	};

	assign irq_o = rx_avail_i | sticky_ovr | sticky_frm | sticky_par;

	always_comb begin
		case (reg_addr_i)
			ADDR_DATA:   rd_mux = rx_avail_i ? (rx_head_i.data & len_mask) : '0;
			ADDR_CTRL:   rd_mux = DATA_W'(cfg_q);	// zero above the 5 format bits
			ADDR_STATUS: rd_mux = status;
			default:     rd_mux = '0;
		endcase
	end

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			cfg_q       <= CTRL_RESET;
			sticky_ovr  <= 1'b0;
			sticky_frm  <= 1'b0;
			sticky_par  <= 1'b0;
			reg_rdata_o <= '0;
		end else begin
			if (wr_ctrl)
				cfg_q <= uart_cfg_t'(reg_wdata_i[$bits(uart_cfg_t)-1:0]);
			if (reg_rd_i)
				reg_rdata_o <= rd_mux;	// held until the next read
			// a new error wins over a clear in the same cycle
			if (rx_overrun_i)
				sticky_ovr <= 1'b1;
			else if (wr_status && reg_wdata_i[7])
				sticky_ovr <= 1'b0;
			if (rx_pop_o && rx_head_i.frame_err)
				sticky_frm <= 1'b1;	// errors of a word show once it is read
			else if (wr_status && reg_wdata_i[6])
				sticky_frm <= 1'b0;
			if (rx_pop_o && rx_head_i.parity_err)
				sticky_par <= 1'b1;
			else if (wr_status && reg_wdata_i[5])
				sticky_par <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/uart_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_framer (
	input  logic                        baud_tick,
	input  logic                        PRESETn,
	input  uart_pkg::uart_cfg_t         cfg_i,
	input  logic                        fifo_empty_i,
	input  logic [uart_pkg::DATA_W-1:0] fifo_head_i,
	output logic                        fifo_pop_o,
	output logic                        txd_o,
	output logic                        tx_busy_o
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	tx_state_t         state;
	logic [3:0]        tick;	// cycle within the current bit
	logic [2:0]        bit_idx;	// data bit, or stop bit number in TX_STOP
	logic [DATA_W-1:0] shreg;
	logic              par;	// xor of bits already sent
	uart_cfg_t         cfg_q;	// format of the frame in flight
	logic [2:0]        last_bit;
	logic              bit_end;
	logic              frame_end;

	assign last_bit  = 3'(cfg_q.data_len) + 3'd4;
	assign bit_end   = (tick == 4'(OVERSAMPLE - 1));
	assign frame_end = (state == TX_STOP) && bit_end && (bit_idx[0] == cfg_q.stop_two);

	// pop when idle, or on the last stop cycle so frames run back to back
	assign fifo_pop_o = !fifo_empty_i && ((state == TX_IDLE) || frame_end);
	assign tx_busy_o  = (state != TX_IDLE);

	always_comb begin
		case (state)
			TX_START:  txd_o = 1'b0;
			TX_DATA:   txd_o = shreg[0];	// lsb first
			TX_PARITY: txd_o = par ^ cfg_q.parity_odd;
			default:   txd_o = 1'b1;	// idle and stop are mark
		endcase
	end

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			state   <= TX_IDLE;
			tick    <= '0;
			bit_idx <= '0;
			par     <= 1'b0;
			cfg_q   <= CTRL_RESET;
		end else if (fifo_pop_o) begin
			state   <= TX_START;	// start bit begins on this edge
			tick    <= '0;
			bit_idx <= '0;
			par     <= 1'b0;
			cfg_q   <= cfg_i;	// new format only at a frame start
		end else if (state != TX_IDLE) begin
			tick <= tick + 4'd1;	// wraps after 16
			if (bit_end) begin
				case (state)
					TX_START: begin
						state   <= TX_DATA;
						bit_idx <= '0;
					end
					TX_DATA: begin
						par <= par ^ shreg[0];
						if (bit_idx == last_bit) begin
							bit_idx <= '0;
							state   <= cfg_q.parity_en ? TX_PARITY : TX_STOP;
						end else begin
							bit_idx <= bit_idx + 3'd1;
						end
					end
					TX_PARITY: state <= TX_STOP;
					TX_STOP: begin
						if (bit_idx[0] == cfg_q.stop_two)
							state <= TX_IDLE;	// nothing queued
						else
							bit_idx <= 3'd1;	// second stop bit
					end
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge baud_tick) begin
		if (fifo_pop_o)
			shreg <= fifo_head_i;
		else if ((state == TX_DATA) && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

// File: source/uart_rx_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler (
	input  logic                baud_tick,
	input  logic                PRESETn,
	input  uart_pkg::uart_cfg_t cfg_i,
	input  logic                rxd_i,
	output logic                push_o,	// one pulse per frame
	output uart_pkg::rx_word_t  word_o
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	logic [1:0] sync;	// two flop synchronizer
	logic       rxd_s;
	rx_state_t  state;
	logic [3:0] tick;
	logic [2:0] bit_idx;	// data bit, or stop bit number in RX_STOP
	logic       par;	// xor of sampled data bits
	uart_cfg_t  cfg_q;
	rx_word_t   word_q;	// character being assembled
	logic [2:0] last_bit;
	logic       bit_end;	// mid-bit sample point
	logic       start_ok;

	assign rxd_s    = sync[1];
	assign last_bit = 3'(cfg_q.data_len) + 3'd4;
	assign bit_end  = (tick == 4'(OVERSAMPLE - 1));
	assign start_ok = (state == RX_START) && (tick == 4'(MID_SAMPLE)) && !rxd_s;
	assign word_o   = word_q;

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn)
			sync <= 2'b11;	// line idles high
		else
			sync <= {sync[0], rxd_i};
	end

	always_ff @(posedge baud_tick or negedge PRESETn) begin
		if (!PRESETn) begin
			state   <= RX_IDLE;
			tick    <= '0;
			bit_idx <= '0;
			par     <= 1'b0;
			cfg_q   <= CTRL_RESET;
			push_o  <= 1'b0;
		end else begin
			push_o <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (!rxd_s) begin
						state <= RX_START;
						tick  <= 4'd1;	// detect edge counts as zero
					end
				end
				RX_START: begin
					if (tick == 4'(MID_SAMPLE)) begin
						if (rxd_s) begin
							state <= RX_IDLE;	// glitch, back to hunting
						end else begin
							state   <= RX_DATA;
							tick    <= '0;
							bit_idx <= '0;
							par     <= 1'b0;
							cfg_q   <= cfg_i;
						end
					end else begin
						tick <= tick + 4'd1;
					end
				end
				RX_DATA: begin
					tick <= tick + 4'd1;
					if (bit_end) begin
						par <= par ^ rxd_s;
						if (bit_idx == last_bit) begin
							bit_idx <= '0;
							state   <= cfg_q.parity_en ? RX_PARITY : RX_STOP;
						end else begin
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				RX_PARITY: begin
					tick <= tick + 4'd1;
					if (bit_end)
						state <= RX_STOP;
				end
				RX_STOP: begin
					tick <= tick + 4'd1;
					if (bit_end) begin
						if (bit_idx[0] == cfg_q.stop_two) begin
							state  <= RX_IDLE;
							push_o <= 1'b1;	// word_q completes on the same edge
						end else begin
							bit_idx <= 3'd1;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// character and error bits
	always_ff @(posedge baud_tick) begin
		if (start_ok) begin
			word_q <= '0;	// unused upper data bits stay zero
		end else if (bit_end) begin
			case (state)
				RX_DATA:   word_q.data[bit_idx] <= rxd_s;
				RX_PARITY: word_q.parity_err <= par ^ rxd_s ^ cfg_q.parity_odd;
				RX_STOP: begin
					if (!rxd_s)
						word_q.frame_err <= 1'b1;	// any low stop sample
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core (
	input  logic                        baud_tick,
	input  logic                        PRESETn,
	input  logic                        reg_wr_i,
	input  logic                        reg_rd_i,
	input  logic [uart_pkg::ADDR_W-1:0] reg_addr_i,
	input  logic [uart_pkg::DATA_W-1:0] reg_wdata_i,
	output logic [uart_pkg::DATA_W-1:0] reg_rdata_o,
	input  logic                        rxd_i,
	output logic                        txd_o,
	output logic                        irq_o
);
	import uart_pkg::*;

	uart_cfg_t         cfg;
	logic              tx_push, tx_pop;
	logic              tx_full, tx_empty, tx_busy;
	logic [DATA_W-1:0] tx_head;
	logic              rx_push, rx_pop;
	logic              rx_full, rx_empty, rx_overrun;
	rx_word_t          rx_word;	// sampler to fifo
	rx_word_t          rx_head;	// fifo to register block

	uart_cfg_regs u_regs (
		.baud_tick    (baud_tick),
		.PRESETn      (PRESETn),
		.reg_wr_i     (reg_wr_i),
		.reg_rd_i     (reg_rd_i),
		.reg_addr_i   (reg_addr_i),
		.reg_wdata_i  (reg_wdata_i),
		.reg_rdata_o  (reg_rdata_o),
		.irq_o        (irq_o),
		.cfg_o        (cfg),
		.tx_push_o    (tx_push),
		.tx_full_i    (tx_full),
		.tx_empty_i   (tx_empty),
		.tx_busy_i    (tx_busy),
		.rx_pop_o     (rx_pop),
		.rx_head_i    (rx_head),
		.rx_avail_i   (!rx_empty),
		.rx_full_i    (rx_full),
		.rx_overrun_i (rx_overrun)
	);

	// tx side carries raw bytes, a dropped push there is not reported
	uart_sync_fifo #(
		.payload_t (logic [DATA_W-1:0]),
		.DEPTH     (FIFO_DEPTH)
	) u_tx_fifo (
		.baud_tick   (baud_tick),
		.PRESETn     (PRESETn),
		.push_i      (tx_push),
		.push_data_i (reg_wdata_i),
		.pop_i       (tx_pop),
		.head_o      (tx_head),
		.full_o      (tx_full),
		.empty_o     (tx_empty),
		.overrun_o   ()
	);

	uart_tx_framer u_tx (
		.baud_tick    (baud_tick),
		.PRESETn      (PRESETn),
		.cfg_i        (cfg),
		.fifo_empty_i (tx_empty),
		.fifo_head_i  (tx_head),
		.fifo_pop_o   (tx_pop),
		.txd_o        (txd_o),
		.tx_busy_o    (tx_busy)
	);

	uart_rx_sampler u_rx (
		.baud_tick (baud_tick),
		.PRESETn   (PRESETn),
		.cfg_i     (cfg),
		.rxd_i     (rxd_i),
		.push_o    (rx_push),
		.word_o    (rx_word)
	);

	uart_sync_fifo #(
		.payload_t (rx_word_t),
		.DEPTH     (FIFO_DEPTH)
	) u_rx_fifo (
		.baud_tick   (baud_tick),
		.PRESETn     (PRESETn),
		.push_i      (rx_push),
		.push_data_i (rx_word),
		.pop_i       (rx_pop),
		.head_o      (rx_head),
		.full_o      (rx_full),
		.empty_o     (rx_empty),
		.overrun_o   (rx_overrun)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial clk_o = 1'b0;
	always #20 clk_o = ~clk_o;	// 40 ns period

	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o) rst_n_o = 1'b1;	// release away from the active edge
	end

endmodule

`default_nettype wire

// File: sim/tb_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_core;
	import uart_pkg::*;

	logic              baud_tick, PRESETn;
	logic              reg_wr, reg_rd;
	logic [ADDR_W-1:0] reg_addr;
	logic [DATA_W-1:0] reg_wdata, reg_rdata;
	logic              rxd, txd, irq;
	logic              loop_sel;	// 1 loops txd back, 0 uses the serial driver
	logic              drv_rxd;
	integer            seed;
	int                errors, test_errs, pass_cnt, fail_cnt, nframes;
	logic [7:0]        rd, b, cap_data, tx_q[$];
	logic              cap_seen, cap_start, cap_par;
	logic [1:0]        cap_stop;
	uart_status_t      st;

	tb_clock_gen u_clk (.clk_o(baud_tick), .rst_n_o(PRESETn));

	assign rxd = loop_sel ? txd : drv_rxd;

	uart_core UUT (
		.baud_tick   (baud_tick),
		.PRESETn     (PRESETn),
		.reg_wr_i    (reg_wr),
		.reg_rd_i    (reg_rd),
		.reg_addr_i  (reg_addr),
		.reg_wdata_i (reg_wdata),
		.reg_rdata_o (reg_rdata),
		.rxd_i       (rxd),
		.txd_o       (txd),
		.irq_o       (irq)
	);

	task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: %s, read %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("FAIL %0t: %s", $time, what);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errs) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		@(negedge baud_tick);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge baud_tick);
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
		@(negedge baud_tick);
		reg_rd   = 1'b1;
		reg_addr = addr;
		@(negedge baud_tick);
		reg_rd = 1'b0;
		data   = reg_rdata;	// registered on the edge between
	endtask

	// polls STATUS until rx_avail, irq must follow it
	task automatic wait_rx_avail();
		logic [7:0] s;
		for (int i = 0; i < 400; i++) begin
			reg_read(ADDR_STATUS, s);
			if (s[1]) begin
				check_true(irq, "irq low while rx_avail set");
				return;
			end
		end
		timeout_fail("rx_avail never rose");
	endtask

	task automatic wait_tx_space();
		logic [7:0] s;
		for (int i = 0; i < 400; i++) begin
			reg_read(ADDR_STATUS, s);
			if (!s[4])
				return;
		end
		timeout_fail("tx_full never cleared");
	endtask

	// samples txd at mid-bit; seen stays low if no start bit within max_wait
	task automatic capture_tx_frame(input int nbits, input bit has_par, input int nstop,
			input int max_wait, output logic seen, output logic start_bit,
			output logic [7:0] data, output logic par_bit, output logic [1:0] stops);
		seen  = 1'b0;
		data  = '0;
		stops = '0;
		for (int i = 0; i < max_wait && !seen; i++) begin
			@(negedge baud_tick);
			if (!txd)
				seen = 1'b1;	// half a cycle into the start bit
		end
		if (!seen)
			return;
		repeat (OVERSAMPLE / 2 - 1) @(negedge baud_tick);
		start_bit = txd;
		for (int k = 0; k < nbits; k++) begin
			repeat (OVERSAMPLE) @(negedge baud_tick);
			data[k] = txd;
		end
		if (has_par) begin
			repeat (OVERSAMPLE) @(negedge baud_tick);
			par_bit = txd;
		end
		for (int k = 0; k < nstop; k++) begin
			repeat (OVERSAMPLE) @(negedge baud_tick);
			stops[k] = txd;
		end
	endtask

	// serial driver, bad_stop pulls the first stop bit low for part of the bit
	task automatic send_frame(input logic [7:0] d, input int nbits, input bit par_en,
			input bit odd, input bit two_stop, input bit bad_par, input bit bad_stop);
		logic p;
		p = odd;
		@(negedge baud_tick);
		drv_rxd = 1'b0;
		repeat (OVERSAMPLE) @(negedge baud_tick);
		for (int k = 0; k < nbits; k++) begin
			drv_rxd = d[k];
			p ^= d[k];
			repeat (OVERSAMPLE) @(negedge baud_tick);
		end
		if (par_en) begin
			drv_rxd = p ^ bad_par;
			repeat (OVERSAMPLE) @(negedge baud_tick);
		end
		if (bad_stop) begin
			drv_rxd = 1'b0;
			repeat (OVERSAMPLE / 2 + 2) @(negedge baud_tick);	// low past the sample point
			drv_rxd = 1'b1;
			repeat (OVERSAMPLE / 2 - 2) @(negedge baud_tick);
		end else begin
			drv_rxd = 1'b1;
			repeat (OVERSAMPLE) @(negedge baud_tick);
		end
		if (two_stop)
			repeat (OVERSAMPLE) @(negedge baud_tick);
	endtask

	initial begin
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		drv_rxd = 1'b1;
		loop_sel = 1'b1;
		seed = 82565;
		errors = 0;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		for (int i = 0; i < 50 && PRESETn !== 1'b1; i++)
			@(negedge baud_tick);
		if (PRESETn !== 1'b1)
			timeout_fail("reset never released");

		// reset state
		check_true(txd && !irq, "txd low or irq high after reset");
		reg_read(ADDR_CTRL, rd);
		check_eq(rd, 8'h18, "CTRL after reset");	// 8 data bits, no parity, one stop
		reg_read(ADDR_STATUS, rd);
		check_eq(rd, 8'h08, "STATUS after reset");
		end_test("reset");

		// 8N1 loopback, more bytes than the tx fifo holds
		for (int i = 0; i < 12; i++) begin
			b = 8'($random(seed));
			tx_q.push_back(b);
			if (i >= FIFO_DEPTH)
				wait_tx_space();
			reg_write(ADDR_DATA, b);
		end
		for (int i = 0; i < 12; i++) begin
			wait_rx_avail();
			reg_read(ADDR_DATA, rd);
			check_eq(rd, tx_q[i], "loopback byte");
		end
		end_test("loopback_8n1");

		// 7 bits, odd parity, two stop bits
		reg_write(ADDR_CTRL, 8'h17);
		b = 8'($random(seed));
		reg_write(ADDR_DATA, b);
		capture_tx_frame(7, 1, 2, 100, cap_seen, cap_start, cap_data, cap_par, cap_stop);
		if (!cap_seen)
			timeout_fail("txd never fell for the 7O2 frame");
		check_true(!cap_start, "start bit not low");
		check_eq(cap_data, {1'b0, b[6:0]}, "7-bit data on txd");
		check_true(cap_par === ~^b[6:0], "odd parity bit wrong");
		check_true(cap_stop === 2'b11, "stop bits not high");
		wait_rx_avail();
		reg_read(ADDR_DATA, rd);
		check_eq(rd, {1'b0, b[6:0]}, "7-bit readback");
		end_test("frame_format");

		// parity error from the driver, 8 bits even parity
		loop_sel = 1'b0;
		reg_write(ADDR_CTRL, 8'h1C);
		b = 8'($random(seed));
		send_frame(b, 8, 1, 0, 0, 1, 0);
		wait_rx_avail();
		reg_read(ADDR_DATA, rd);
		check_eq(rd, b, "byte with parity error");
		reg_read(ADDR_STATUS, st);
		check_true(st.parity_err, "parity_err not set");
		reg_read(ADDR_STATUS, st);
		check_true(st.parity_err, "parity_err not sticky");
		reg_write(ADDR_STATUS, 8'h20);
		reg_read(ADDR_STATUS, st);
		check_true(!st.parity_err, "parity_err not cleared");
		end_test("parity_error");

		// frame error, back to 8N1
		reg_write(ADDR_CTRL, 8'h18);
		b = 8'($random(seed));
		send_frame(b, 8, 0, 0, 0, 0, 1);
		wait_rx_avail();
		reg_read(ADDR_DATA, rd);
		check_eq(rd, b, "byte with frame error");
		reg_read(ADDR_STATUS, st);
		check_true(st.frame_err, "frame_err not set");
		check_true(irq, "irq low with frame_err set");
		reg_write(ADDR_STATUS, 8'h40);
		reg_read(ADDR_STATUS, st);
		check_true(!st.frame_err, "frame_err not cleared");
		check_true(!irq, "irq high after clear");
		end_test("frame_error");

		// rx overrun, one frame more than the fifo holds
		tx_q.delete();
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			b = 8'($random(seed));
			tx_q.push_back(b);
			send_frame(b, 8, 0, 0, 0, 0, 0);
		end
		reg_read(ADDR_STATUS, st);
		check_true(st.rx_overrun && st.rx_full, "rx_overrun or rx_full not set");
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			reg_read(ADDR_DATA, rd);
			check_eq(rd, tx_q[i], "byte kept across overrun");
		end
		reg_write(ADDR_STATUS, 8'h80);
		reg_read(ADDR_STATUS, rd);
		check_eq(rd, 8'h08, "STATUS after overrun clear");

		// tx overflow, the last push is dropped
		tx_q.delete();
		nframes = 0;
		fork
			begin
				for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
					b = 8'($random(seed));
					tx_q.push_back(b);
					reg_write(ADDR_DATA, b);
				end
				reg_read(ADDR_STATUS, st);
				check_true(st.tx_full, "tx_full not set");
			end
			begin
				do begin
					capture_tx_frame(8, 0, 1, 300, cap_seen, cap_start, cap_data, cap_par,
						cap_stop);
					if (cap_seen) begin
						check_eq(cap_data, tx_q[nframes], "byte on txd");
						nframes++;
					end
				end while (cap_seen && nframes <= FIFO_DEPTH + 1);
			end
		join
		check_true(nframes == FIFO_DEPTH + 1, "wrong number of frames on txd");
		end_test("overruns");

		$display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
source/uart_pkg.sv
source/uart_sync_fifo.sv
source/uart_cfg_regs.sv
source/uart_tx_framer.sv
source/uart_rx_sampler.sv
source/uart_core.sv
sim/tb_clock_gen.sv
sim/tb_uart_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the uart testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_core \
	-f list.f \
	-o tb_uart_core

./obj_dir/tb_uart_core > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
